/* scc_avl_ctrl.sv */
// Avalon command decode with access pipe, scan request level, group register and read data mux
`timescale 1ns/1ps

module scc_avl_ctrl import scc_mgr_pkg::*; (
	input  logic avl_clk,
	input  logic reset_n_scc_clk,
	input  avl_req_t req,
	input  logic [AVL_DATA_WIDTH-1:0] field,
	input  logic scan_done,
	output rfile_cmd_t rfile_cmd,
	output scan_req_t scan_req,
	output logic [AVL_DATA_WIDTH-1:0] readdata,
	output logic waitrequest
);

	sec_t sec;
	scan_kind_t req_kind;
	logic [7:0] req_pin;
	logic is_group;
	logic is_setting;
	logic is_scan;
	logic req_valid;

	// Bit 1 is the write stage, bit 0 the completion stage
	logic [RFILE_LATENCY-2:0] rfile_pipe;
	logic rfile_begin;
	logic rfile_end;
	logic wr_stage;

	logic scan_active;
	logic scan_begin;
	logic scan_end;
	scan_kind_t scan_kind_q;
	logic [7:0] scan_pin_q;
	logic [7:0] group_q;
	logic ready;

	logic [RFILE_ADDR_WIDTH-1:0] setting_addr;
	logic [RFILE_ADDR_WIDTH-1:0] scan_addr;

	assign sec = sec_t'(req.address[9:6]);
	assign req_kind = scan_kind_t'(req.address[3:0]);
	assign req_pin = req.writedata[7:0];
	assign req_valid = req.read || req.write;

	assign is_group = (sec == SEC_GROUP);
	assign is_setting = (sec >= SEC_DQS_IN_DELAY) && (sec <= SEC_IO_IN_DELAY);
	assign is_scan = (sec == SEC_SCAN);

	assign rfile_begin = req_valid && (is_group || is_setting) && ~(|rfile_pipe);
	assign rfile_end = rfile_pipe[0];
	assign wr_stage = rfile_pipe[RFILE_LATENCY-2];

	assign scan_begin = req_valid && is_scan && ~scan_active && ~scan_done;
	assign scan_end = scan_active && scan_done;

	// I/O view sections start after the group entries
	assign setting_addr = ((sec >= SEC_IO_OUT1_DELAY) ? IO_RFILE_BASE : DQS_RFILE_BASE)
		+ req.address[RFILE_ADDR_WIDTH-1:0];
	assign scan_addr = SCAN_OFFSET[req_kind[1:0]]
		+ ((req_pin == PIN_BROADCAST) ? '0 : req_pin[RFILE_ADDR_WIDTH-1:0]);

	always_ff @(posedge avl_clk or negedge reset_n_scc_clk) begin
		if (!reset_n_scc_clk) begin
			ready <= 1'b0;
			rfile_pipe <= '0;
			scan_active <= 1'b0;
			scan_kind_q <= SCAN_DQS;
			scan_pin_q <= '0;
			group_q <= '0;
		end else begin
			ready <= 1'b1;
			rfile_pipe <= {rfile_begin, rfile_pipe[RFILE_LATENCY-2:1]};
			scan_active <= (scan_begin || scan_active) && ~scan_done;
			if (scan_begin) begin
				scan_kind_q <= req_kind;
				scan_pin_q <= req_pin;
			end
			if (is_group && req.write && wr_stage) begin
				group_q <= req.writedata[7:0];
			end
		end
	end

	assign rfile_cmd.rd_addr = is_scan ? scan_addr : setting_addr;
	assign rfile_cmd.wr_addr = setting_addr;
	assign rfile_cmd.wr_en = is_setting && req.write && wr_stage;
	assign rfile_cmd.section = sec;

	assign scan_req.active = scan_active;
	assign scan_req.kind = scan_kind_q;
	assign scan_req.pin = scan_pin_q;
	assign scan_req.group = group_q;

	assign readdata = is_setting ? field : {{(AVL_DATA_WIDTH-8){1'b0}}, group_q};
	assign waitrequest = ~ready || (req_valid && ~rfile_end && ~scan_end);

	// Pin ranges the enable decoder can handle
	assert property (@(posedge avl_clk) disable iff (!reset_n_scc_clk)
		(scan_begin && req_kind == SCAN_DQS_IO) |-> (req_pin == PIN_BROADCAST || req_pin == 8'd0));
	assert property (@(posedge avl_clk) disable iff (!reset_n_scc_clk)
		(scan_begin && req_kind == SCAN_DQ_IO) |-> (req_pin == PIN_BROADCAST || req_pin < DQ_PER_DQS));
	assert property (@(posedge avl_clk) disable iff (!reset_n_scc_clk)
		(is_group && req.write && wr_stage) |-> (req.writedata < DQS_GROUPS));

endmodule

/* scc_ena_decode.sv */
// Enable mask decode from scan kind, pin and current DQS group
`timescale 1ns/1ps

module scc_ena_decode import scc_mgr_pkg::*; (
	input  scan_req_t scan_req,
	output ena_t ena
);

	logic broadcast;
	logic [GROUP_IDX_WIDTH-1:0] grp;
	logic [DQ_IDX_WIDTH-1:0] dq_idx;
	logic [DQ_IDX_WIDTH-1:0] dq_base;

	assign broadcast = (scan_req.pin == PIN_BROADCAST);
	assign grp = scan_req.group[GROUP_IDX_WIDTH-1:0];

	// Group times DQ_PER_DQS plus pin
	assign dq_idx = {grp, scan_req.pin[DQ_PIN_BITS-1:0]};
	assign dq_base = {grp, {DQ_PIN_BITS{1'b0}}};

	always_comb begin
		ena = '0;
		case (scan_req.kind)
			SCAN_DQS: begin
				if (broadcast) begin
					ena.dqs = '1;
				end else begin
					ena.dqs[scan_req.pin[GROUP_IDX_WIDTH-1:0]] = 1'b1;
				end
			end
			SCAN_DQ_IO: begin
				if (broadcast) begin
					ena.dq[dq_base +: DQ_PER_DQS] = '1;
				end else begin
					ena.dq[dq_idx] = 1'b1;
				end
			end
			// One DQS I/O and one DM pin per group, broadcast is the same bit
			SCAN_DQS_IO: begin
				ena.dqs_io[grp] = 1'b1;
			end
			SCAN_DM_IO: begin
				ena.dm[grp] = 1'b1;
			end
			default: begin
				ena = '0;
			end
		endcase
	end

endmodule

/* scc_mgr.f */
+incdir+.
scc_mgr_pkg.sv
scc_avl_ctrl.sv
scc_setting_store.sv
scc_ena_decode.sv
scc_scan_engine.sv
scc_mgr.sv
scc_mgr_tb.sv

/* scc_mgr.sv */
// Scan-chain configuration manager top, connects the Avalon slave, setting store and scan path
`timescale 1ns/1ps

module scc_mgr import scc_mgr_pkg::*; (
	input  logic avl_clk,
	input  logic reset_n_scc_clk,
	input  logic [AVL_ADDR_WIDTH-1:0] avl_address,
	input  logic avl_read,
	input  logic avl_write,
	input  logic [AVL_DATA_WIDTH-1:0] avl_writedata,
	output logic [AVL_DATA_WIDTH-1:0] avl_readdata,
	output logic avl_waitrequest,
	output logic scc_data,
	output logic [DQS_GROUPS-1:0] scc_dqs_ena,
	output logic [DQS_GROUPS-1:0] scc_dqs_io_ena,
	output logic [DQ_WIDTH-1:0] scc_dq_ena,
	output logic [DM_WIDTH-1:0] scc_dm_ena,
	output logic scc_upd
);

	avl_req_t avl_req;
	rfile_cmd_t rfile_cmd;
	scan_req_t scan_req;
	logic [AVL_DATA_WIDTH-1:0] field;
	setting_u word;
	ena_t ena_dec;
	ena_t ena_out;
	logic scan_done;

	assign avl_req = '{
		address: avl_address,
		read: avl_read,
		write: avl_write,
		writedata: avl_writedata
	};

	scc_avl_ctrl scc_avl_ctrl_inst (
		.avl_clk         (avl_clk),
		.reset_n_scc_clk (reset_n_scc_clk),
		.req             (avl_req),
		.field           (field),
		.scan_done       (scan_done),
		.rfile_cmd       (rfile_cmd),
		.scan_req        (scan_req),
		.readdata        (avl_readdata),
		.waitrequest     (avl_waitrequest)
	);

	scc_setting_store scc_setting_store_inst (
		.avl_clk         (avl_clk),
		.reset_n_scc_clk (reset_n_scc_clk),
		.cmd             (rfile_cmd),
		.writedata       (avl_writedata),
		.field           (field),
		.word            (word)
	);

	scc_ena_decode scc_ena_decode_inst (
		.scan_req (scan_req),
		.ena      (ena_dec)
	);

	scc_scan_engine scc_scan_engine_inst (
		.avl_clk         (avl_clk),
		.reset_n_scc_clk (reset_n_scc_clk),
		.scan_req        (scan_req),
		.word            (word),
		.ena_in          (ena_dec),
		.scc_data        (scc_data),
		.ena_out         (ena_out),
		.scc_upd         (scc_upd),
		.scan_done       (scan_done)
	);

	assign scc_dqs_ena = ena_out.dqs;
	assign scc_dqs_io_ena = ena_out.dqs_io;
	assign scc_dq_ena = ena_out.dq;
	assign scc_dm_ena = ena_out.dm;

endmodule

/* scc_mgr_pkg.sv */
// Scan-chain configuration manager shared sizes, address map, setting word views and bus structs
package scc_mgr_pkg;

	// Avalon slave port
	localparam int AVL_ADDR_WIDTH = 10;
	localparam int AVL_DATA_WIDTH = 32;

	// Memory interface geometry
	localparam int DQS_GROUPS = 2;
	localparam int DQ_PER_DQS = 8;
	localparam int DQ_WIDTH = DQS_GROUPS * DQ_PER_DQS;
	localparam int DM_WIDTH = DQS_GROUPS;
	localparam int GROUP_IDX_WIDTH = $clog2(DQS_GROUPS);
	localparam int DQ_PIN_BITS = $clog2(DQ_PER_DQS);
	localparam int DQ_IDX_WIDTH = $clog2(DQ_WIDTH);

	// Register file and chain lengths
	localparam int SETTING_WIDTH = 24;
	localparam int RFILE_DEPTH = 16;
	localparam int RFILE_USED = 12;
	localparam int RFILE_ADDR_WIDTH = $clog2(RFILE_DEPTH);
	localparam int DQS_SDATA_BITS = 24;
	localparam int IO_SDATA_BITS = 11;
	localparam int SHIFT_CNT_WIDTH = $clog2(DQS_SDATA_BITS);
	localparam int RFILE_LATENCY = 3;
	localparam logic [7:0] PIN_BROADCAST = 8'hFF;

	// Base entries of the two setting views
	localparam logic [RFILE_ADDR_WIDTH-1:0] DQS_RFILE_BASE = 4'd0;
	localparam logic [RFILE_ADDR_WIDTH-1:0] IO_RFILE_BASE = 4'd2;

	// Address bits 9..6
	typedef enum logic [3:0] {
		SEC_GROUP           = 4'h0,
		SEC_DQS_IN_DELAY    = 4'h1,
		SEC_DQS_EN_PHASE    = 4'h2,
		SEC_DQS_EN_DELAY    = 4'h3,
		SEC_DQDQS_OUT_PHASE = 4'h4,
		SEC_OCT_OUT1_DELAY  = 4'h5,
		SEC_OCT_OUT2_DELAY  = 4'h6,
		SEC_IO_OUT1_DELAY   = 4'h7,
		SEC_IO_OUT2_DELAY   = 4'h8,
		SEC_IO_IN_DELAY     = 4'h9,
		SEC_SCAN            = 4'he
	} sec_t;

	// Address bits 3..0 of a scan access
	typedef enum logic [3:0] {
		SCAN_DQS    = 4'h0,
		SCAN_DQS_IO = 4'h1,
		SCAN_DQ_IO  = 4'h2,
		SCAN_DM_IO  = 4'h3,
		SCAN_UPD    = 4'h8
	} scan_kind_t;

	// Field placement per section, unused sections are zero
	localparam logic [4:0] FIELD_OFFSET [16] = '{
		5'd0, 5'd0, 5'd4, 5'd8, 5'd12, 5'd17, 5'd21, 5'd0,
		5'd4, 5'd7, 5'd0, 5'd0, 5'd0, 5'd0, 5'd0, 5'd0
	};
	localparam logic [SETTING_WIDTH-1:0] FIELD_MASK [16] = '{
		24'h0, 24'hf, 24'hf, 24'hf, 24'h1f, 24'hf, 24'h7, 24'hf,
		24'h7, 24'hf, 24'h0, 24'h0, 24'h0, 24'h0, 24'h0, 24'h0
	};

	// Start entry of each scan kind, indexed by kind bits 1..0
	localparam logic [RFILE_ADDR_WIDTH-1:0] SCAN_OFFSET [4] = '{4'd0, 4'd10, 4'd2, 4'd11};

	typedef struct packed {
		logic [2:0] oct_out2_delay;
		logic [3:0] oct_out1_delay;
		logic [4:0] dqdqs_out_phase;
		logic [3:0] dqs_en_delay;
		logic [3:0] dqs_en_phase;
		logic [3:0] dqs_in_delay;
	} dqs_view_t;

	typedef struct packed {
		logic [12:0] unused;
		logic [3:0] io_in_delay;
		logic [2:0] io_out2_delay;
		logic [3:0] io_out1_delay;
	} io_view_t;

	// One register-file word seen as a group setting or a pin setting
	typedef union packed {
		dqs_view_t dqs;
		io_view_t io;
	} setting_u;

	typedef struct packed {
		logic [AVL_ADDR_WIDTH-1:0] address;
		logic read;
		logic write;
		logic [AVL_DATA_WIDTH-1:0] writedata;
	} avl_req_t;

	typedef struct packed {
		logic [RFILE_ADDR_WIDTH-1:0] rd_addr;
		logic [RFILE_ADDR_WIDTH-1:0] wr_addr;
		logic wr_en;
		sec_t section;
	} rfile_cmd_t;

	typedef struct packed {
		logic active;
		scan_kind_t kind;
		logic [7:0] pin;
		logic [7:0] group;
	} scan_req_t;

	typedef struct packed {
		logic [DQS_GROUPS-1:0] dqs;
		logic [DQS_GROUPS-1:0] dqs_io;
		logic [DQ_WIDTH-1:0] dq;
		logic [DM_WIDTH-1:0] dm;
	} ena_t;

endpackage

/* scc_mgr_tb_model.svh */
// Testbench reference model of the setting words and group register plus the check and bus tasks
`ifndef SCC_MGR_TB_MODEL_SVH
`define SCC_MGR_TB_MODEL_SVH

localparam int BUS_TIMEOUT = 200;

logic [23:0] model_word [12];
logic [7:0] model_group;
int check_count;
int error_count;
bit cap_data [$];
logic [31:0] cap_ena [$];
int upd_count;

// Field layout of the two views counted from the LSB
function automatic int field_lsb(input logic [3:0] sec);
	case (sec)
		4'd2: return 4;
		4'd3: return 8;
		4'd4: return 12;
		4'd5: return 17;
		4'd6: return 21;
		4'd8: return 4;
		4'd9: return 7;
		default: return 0;
	endcase
endfunction

function automatic int field_bits(input logic [3:0] sec);
	case (sec)
		4'd4: return 5;
		4'd6, 4'd8: return 3;
		default: return 4;
	endcase
endfunction

// DQS view starts at entry 0, I/O view at entry 2
function automatic int model_entry(input logic [3:0] sec, input logic [3:0] idx);
	return (sec >= 4'd7) ? 2 + int'(idx) : int'(idx);
endfunction

task automatic model_write(input logic [3:0] sec, input logic [3:0] idx, input logic [31:0] value);
	logic [23:0] mask;
	int e;
	mask = (24'd1 << field_bits(sec)) - 24'd1;
	e = model_entry(sec, idx);
	model_word[e] = (model_word[e] & ~(mask << field_lsb(sec)))
		| ((value[23:0] & mask) << field_lsb(sec));
endtask

function automatic logic [31:0] model_field(input logic [3:0] sec, input logic [3:0] idx);
	logic [23:0] mask;
	mask = (24'd1 << field_bits(sec)) - 24'd1;
	return {8'h0, (model_word[model_entry(sec, idx)] >> field_lsb(sec)) & mask};
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
	input logic [31:0] actual);
	check_count++;
	if (expected !== actual) begin
		error_count++;
		$display("Error at time %0t: %s expected 0x%0h, actual 0x%0h",
			$time, name, expected, actual);
	end
endtask

// Collect serial data and enables while any chain is selected
task automatic capture_outputs();
	logic [31:0] ena;
	ena = {10'h0, scc_dqs_ena, scc_dqs_io_ena, scc_dq_ena, scc_dm_ena};
	if (ena != 32'h0) begin
		cap_data.push_back(scc_data);
		cap_ena.push_back(ena);
	end
	if (scc_upd) begin
		upd_count++;
	end
endtask

// One Avalon access held until waitrequest is seen low
task automatic bus_access(input logic wr, input logic [9:0] addr, input logic [31:0] data,
	output logic [31:0] rdata);
	int cycles;
	logic done;
	@(posedge avl_clk);
	avl_address <= addr;
	avl_read <= ~wr;
	avl_write <= wr;
	avl_writedata <= data;
	cap_data.delete();
	cap_ena.delete();
	upd_count = 0;
	cycles = 0;
	done = 1'b0;
	while (!done) begin
		@(negedge avl_clk);
		cycles++;
		capture_outputs();
		if (!avl_waitrequest) begin
			done = 1'b1;
		end else if (cycles >= BUS_TIMEOUT) begin
			end_with_failure($sformatf("Timeout: waitrequest still high %0d cycles after access to 0x%0h",
				cycles, addr));
		end
	end
	rdata = avl_readdata;
	// Group and setting accesses complete in the third cycle of the request
	if (addr[9:6] <= 4'd9) begin
		check_value("avl_waitrequest low cycle", 32'd3, 32'(cycles));
	end
	@(posedge avl_clk);
	avl_read <= 1'b0;
	avl_write <= 1'b0;
endtask

`endif

/* scc_mgr_tb.sv */
// Testbench for the scan-chain configuration manager with random field writes and scan checks
`timescale 1ns/1ps

module scc_mgr_tb import scc_mgr_pkg::*; ();

	logic avl_clk;
	logic reset_n_scc_clk;
	logic [9:0] avl_address;
	logic avl_read;
	logic avl_write;
	logic [31:0] avl_writedata;
	logic [31:0] avl_readdata;
	logic avl_waitrequest;
	logic scc_data;
	logic [1:0] scc_dqs_ena;
	logic [1:0] scc_dqs_io_ena;
	logic [15:0] scc_dq_ena;
	logic [1:0] scc_dm_ena;
	logic scc_upd;

	logic [31:0] rng_state;
	int test_checks;
	int test_errors;

	scc_mgr scc_mgr_inst (
		.avl_clk         (avl_clk),
		.reset_n_scc_clk (reset_n_scc_clk),
		.avl_address     (avl_address),
		.avl_read        (avl_read),
		.avl_write       (avl_write),
		.avl_writedata   (avl_writedata),
		.avl_readdata    (avl_readdata),
		.avl_waitrequest (avl_waitrequest),
		.scc_data        (scc_data),
		.scc_dqs_ena     (scc_dqs_ena),
		.scc_dqs_io_ena  (scc_dqs_io_ena),
		.scc_dq_ena      (scc_dq_ena),
		.scc_dm_ena      (scc_dm_ena),
		.scc_upd         (scc_upd)
	);

	task automatic end_with_failure(input string reason);
		$display("%s", reason);
		$display("Checks failed");
		$finish;
	endtask

	`include "scc_mgr_tb_model.svh"

	initial begin
		avl_clk = 1'b0;
		forever #4 avl_clk = ~avl_clk;
	end

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic int rand_below(input int n);
		return int'((lcg_next() >> 8) % n);
	endfunction

	function automatic logic [31:0] ena_word(input logic [1:0] dqs, input logic [1:0] dqs_io,
		input logic [15:0] dq, input logic [1:0] dm);
		return {10'h0, dqs, dqs_io, dq, dm};
	endfunction

	task automatic begin_test();
		test_checks = check_count;
		test_errors = error_count;
	endtask

	task automatic end_test(input string name);
		$display("Test %s: %0d checks, %0d errors", name, check_count - test_checks,
			error_count - test_errors);
	endtask

	task automatic set_group(input int g);
		logic [31:0] rdata;
		bus_access(1'b1, {SEC_GROUP, 6'h0}, 32'(g), rdata);
		model_group = 8'(g);
	endtask

	task automatic scan_and_check(input string label, input logic [3:0] kind,
		input logic [7:0] pin, input int entry, input int nbits, input logic [31:0] exp_ena);
		logic [31:0] rdata;
		bus_access(1'b1, {SEC_SCAN, 2'b00, kind}, {24'h0, pin}, rdata);
		check_value({label, " shifted bit count"}, 32'(nbits), 32'(cap_data.size()));
		// MSB of the chain comes out first
		for (int i = 0; i < cap_data.size() && i < nbits; i++) begin
			check_value($sformatf("%s scc_data[%0d]", label, nbits - 1 - i),
				32'(model_word[entry][nbits - 1 - i]), 32'(cap_data[i]));
			check_value($sformatf("%s enables in cycle %0d", label, i), exp_ena, cap_ena[i]);
		end
		check_value({label, " scc_upd pulses"}, 32'h0, 32'(upd_count));
	endtask

	task automatic test_field_writes();
		logic [3:0] sec;
		logic [3:0] idx;
		logic [31:0] value;
		logic [31:0] rdata;
		int first;
		int last;
		begin_test();
		for (int n = 0; n < 40; n++) begin
			sec = 4'(1 + rand_below(9));
			idx = (sec <= 4'd6) ? 4'(rand_below(2)) : 4'(rand_below(10));
			value = lcg_next();
			bus_access(1'b1, {sec, 2'b00, idx}, value, rdata);
			model_write(sec, idx, value);
			// Read back every field of the touched word
			first = (sec <= 4'd6) ? 1 : 7;
			last = (sec <= 4'd6) ? 6 : 9;
			for (int s = first; s <= last; s++) begin
				bus_access(1'b0, {4'(s), 2'b00, idx}, 32'h0, rdata);
				check_value($sformatf("avl_readdata sec %0d entry %0d", s,
					model_entry(4'(s), idx)), model_field(4'(s), idx), rdata);
			end
		end
		end_test("random field writes");
	endtask

	task automatic test_group_register();
		logic [31:0] rdata;
		begin_test();
		for (int n = 0; n < 4; n++) begin
			set_group(rand_below(2));
			bus_access(1'b0, {SEC_GROUP, 6'h0}, 32'h0, rdata);
			check_value("avl_readdata group", {24'h0, model_group}, rdata);
		end
		end_test("group register");
	endtask

	task automatic test_dq_io_scans();
		logic [7:0] pin;
		logic [15:0] dq;
		int entry;
		begin_test();
		for (int n = 0; n < 8; n++) begin
			set_group(rand_below(2));
			if (rand_below(4) == 0) begin
				pin = 8'hFF;
				dq = 16'h00FF << (model_group * 8);
				entry = 2;
			end else begin
				pin = 8'(rand_below(8));
				dq = 16'h1 << (model_group * 8 + pin);
				entry = 2 + pin;
			end
			scan_and_check("dq io scan", SCAN_DQ_IO, pin, entry, 11,
				ena_word(2'b00, 2'b00, dq, 2'b00));
		end
		end_test("dq io scans");
	endtask

	task automatic test_dqs_scans();
		logic [7:0] pin;
		logic [1:0] dqs;
		int choice;
		begin_test();
		for (int n = 0; n < 4; n++) begin
			choice = rand_below(3);
			pin = (choice == 2) ? 8'hFF : 8'(choice);
			dqs = (choice == 2) ? 2'b11 : (2'b01 << choice);
			scan_and_check("dqs scan", SCAN_DQS, pin, (choice == 2) ? 0 : choice, 24,
				ena_word(dqs, 2'b00, 16'h0, 2'b00));
		end
		end_test("dqs scans");
	endtask

	task automatic test_dqs_io_dm_scans();
		logic [7:0] pin;
		begin_test();
		for (int n = 0; n < 4; n++) begin
			set_group(rand_below(2));
			pin = (rand_below(2) == 0) ? 8'h00 : 8'hFF;
			scan_and_check("dqs io scan", SCAN_DQS_IO, pin, 10, 11,
				ena_word(2'b00, 2'b01 << model_group, 16'h0, 2'b00));
			scan_and_check("dm io scan", SCAN_DM_IO, 8'h00, 11, 11,
				ena_word(2'b00, 2'b00, 16'h0, 2'b01 << model_group));
		end
		end_test("dqs io and dm scans");
	endtask

	task automatic test_update_scan();
		logic [31:0] rdata;
		begin_test();
		for (int n = 0; n < 2; n++) begin
			bus_access(1'b1, {SEC_SCAN, 2'b00, SCAN_UPD}, 32'h0, rdata);
			check_value("scc_upd pulses", 32'h1, 32'(upd_count));
			check_value("enable cycles during update", 32'h0, 32'(cap_ena.size()));
			@(negedge avl_clk);
			check_value("scc_upd after update", 32'h0, 32'(scc_upd));
		end
		end_test("update scan");
	endtask

	initial begin
		avl_address = '0;
		avl_read = 1'b0;
		avl_write = 1'b0;
		avl_writedata = '0;
		reset_n_scc_clk = 1'b0;
		rng_state = 32'h8f07_7d39;
		model_group = '0;
		check_count = 0;
		error_count = 0;
		for (int i = 0; i < 12; i++) begin
			model_word[i] = '0;
		end
		repeat (5) @(posedge avl_clk);
		reset_n_scc_clk <= 1'b1;

		test_field_writes();
		test_group_register();
		test_dq_io_scans();
		test_dqs_scans();
		test_dqs_io_dm_scans();
		test_update_scan();

		$display("Total: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			end_with_failure("Some checks reported a wrong value");
		end
	end

endmodule

/* scc_scan_engine.sv */
// Scan FSM that shifts a setting word out MSB first under its enable mask and pulses update
`timescale 1ns/1ps

module scc_scan_engine import scc_mgr_pkg::*; (
	input  logic avl_clk,
	input  logic reset_n_scc_clk,
	input  scan_req_t scan_req,
	input  setting_u word,
	input  ena_t ena_in,
	output logic scc_data,
	output ena_t ena_out,
	output logic scc_upd,
	output logic scan_done
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_DONE
	} state_t;

	state_t state;
	logic [SHIFT_CNT_WIDTH-1:0] shift_cnt;
	logic [SETTING_WIDTH-1:0] shreg;
	logic [SETTING_WIDTH-1:0] io_chain;
	ena_t mask;
	logic start;
	logic is_io_kind;

	assign start = (state == ST_IDLE) && scan_req.active;
	assign is_io_kind = (scan_req.kind == SCAN_DQS_IO) || (scan_req.kind == SCAN_DQ_IO)
		|| (scan_req.kind == SCAN_DM_IO);

	// I/O chain left-aligned so the shift always takes the top bit
	assign io_chain = {word.io.io_in_delay, word.io.io_out2_delay, word.io.io_out1_delay,
		{(SETTING_WIDTH-IO_SDATA_BITS){1'b0}}};

	// Word and mask captured on the first active cycle
	always_ff @(posedge avl_clk) begin
		if (start) begin
			shreg <= is_io_kind ? io_chain : word.dqs;
			mask <= ena_in;
		end else if (state == ST_LOAD) begin
			shreg <= shreg << 1;
		end
	end

	always_ff @(posedge avl_clk or negedge reset_n_scc_clk) begin
		if (!reset_n_scc_clk) begin
			state <= ST_IDLE;
			shift_cnt <= '0;
			scc_data <= 1'b0;
			ena_out <= '0;
			scc_upd <= 1'b0;
		end else begin
			scc_data <= 1'b0;
			ena_out <= '0;
			scc_upd <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (scan_req.active) begin
						if (scan_req.kind == SCAN_DQS) begin
							shift_cnt <= SHIFT_CNT_WIDTH'(DQS_SDATA_BITS - 1);
							state <= ST_LOAD;
						end else if (is_io_kind) begin
							shift_cnt <= SHIFT_CNT_WIDTH'(IO_SDATA_BITS - 1);
							state <= ST_LOAD;
						end else begin
							// Update needs no shifting, unknown kinds just finish
							scc_upd <= (scan_req.kind == SCAN_UPD);
							state <= ST_DONE;
						end
					end
				end
				ST_LOAD: begin
					scc_data <= shreg[SETTING_WIDTH-1];
					ena_out <= mask;
					shift_cnt <= shift_cnt - 1'b1;
					if (shift_cnt == '0) begin
						state <= ST_DONE;
					end
				end
				ST_DONE: begin
					if (!scan_req.active) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Held until the controller drops the active level
	assign scan_done = (state == ST_DONE);

	// Data only toggles while some chain is selected
	assert property (@(posedge avl_clk) disable iff (!reset_n_scc_clk)
		!(|ena_out) |-> !scc_data);

endmodule

/* scc_setting_store.sv */
// Setting register file with per-section field extract and read-modify-write merge
`timescale 1ns/1ps

module scc_setting_store import scc_mgr_pkg::*; (
	input  logic avl_clk,
	input  logic reset_n_scc_clk,
	input  rfile_cmd_t cmd,
	input  logic [AVL_DATA_WIDTH-1:0] writedata,
	output logic [AVL_DATA_WIDTH-1:0] field,
	output setting_u word
);

	logic [SETTING_WIDTH-1:0] mem [RFILE_DEPTH];
	logic [SETTING_WIDTH-1:0] field_mask;
	logic [SETTING_WIDTH-1:0] place_mask;
	logic [SETTING_WIDTH-1:0] merged;
	logic [4:0] field_offset;

	assign field_mask = FIELD_MASK[cmd.section];
	assign field_offset = FIELD_OFFSET[cmd.section];
	assign place_mask = field_mask << field_offset;

	// Keep every bit outside the addressed field
	assign merged = (word & ~place_mask)
		| ((writedata[SETTING_WIDTH-1:0] & field_mask) << field_offset);

	always_ff @(posedge avl_clk or negedge reset_n_scc_clk) begin
		if (!reset_n_scc_clk) begin
			for (int i = 0; i < RFILE_DEPTH; i++) begin
				mem[i] <= '0;
			end
			word <= '0;
		end else begin
			if (cmd.wr_en) begin
				mem[cmd.wr_addr] <= merged;
			end
			word <= mem[cmd.rd_addr];
		end
	end

	// Field right-aligned for readdata
	assign field = {{(AVL_DATA_WIDTH-SETTING_WIDTH){1'b0}}, (word >> field_offset) & field_mask};

	// Entries above the DM pin are never written by the address map
	assert property (@(posedge avl_clk) disable iff (!reset_n_scc_clk)
		cmd.wr_en |-> (cmd.wr_addr < RFILE_USED));

endmodule
